//--- src/iir_pkg.sv
/*
 * IIR filter package
 * Tap count, sample and coefficient widths, accumulator sizing
 * and the signed types shared by the Direct-Form I filter
 */

`default_nettype none

package iir_pkg;

  // ----------------------------------------
  // Filter geometry
  // ----------------------------------------

  // Coefficients per section, numerator and denominator alike
  localparam int TAPS = 3;

  // Stored past values per section
  localparam int HIST_DEPTH = TAPS - 1;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  localparam int IN_W    = 8;
  localparam int OUT_W   = 16;
  localparam int COEFF_W = 8;

  // Growth for summing both sections plus a spare sign bit
  localparam int GUARD_W = $clog2(2 * TAPS) + 1;

  // Widest product is out_t times coeff_t
  localparam int ACC_W = OUT_W + COEFF_W + GUARD_W;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // Input sample
  typedef logic signed [IN_W-1:0]    sample_t;

  // Output sample, also what the feedback history holds
  typedef logic signed [OUT_W-1:0]   out_t;

  // One coefficient
  typedef logic signed [COEFF_W-1:0] coeff_t;

  // Full-precision running sum
  typedef logic signed [ACC_W-1:0]   acc_t;

  // Coefficient set, index k multiplies the value k samples back
  typedef coeff_t coeff_arr_t [TAPS];

endpackage : iir_pkg

`default_nettype wire

//--- src/iir_delay_line.sv
/*
 * IIR history delay line
 * Enabled shift register of DEPTH samples of any payload type,
 * index 0 holds the newest stored value
 */

`timescale 1ns/1ns
`default_nettype none

module iir_delay_line #(
  parameter type T     = logic signed [7:0],
  parameter int  DEPTH = 2
) (
  input  wire   i_clk,
  input  wire   i_arst_n,
  input  wire   i_ena,
  input  wire T i_sample,
  output T      o_taps [DEPTH]
);

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  T taps_q [DEPTH];

  // ----------------------------------------
  // Shift
  // ----------------------------------------

  // Advances one place per enabled edge, holds otherwise
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        taps_q[i] <= '0;
      end
    end
    else if (i_ena)
    begin
      // Newest value enters at the head
      taps_q[0] <= i_sample;

      // Older values move one stage further back
      for (int i = 1; i < DEPTH; i++)
      begin
        taps_q[i] <= taps_q[i-1];
      end
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------

  // Every stage is visible to the multipliers
  assign o_taps = taps_q;

endmodule : iir_delay_line

`default_nettype wire

//--- src/iir_feedforward.sv
/*
 * IIR feed-forward section
 * Input history with the numerator products, summed at full
 * accumulator width. The live sample counts as tap 0
 */

`timescale 1ns/1ns
`default_nettype none

module iir_feedforward
  import iir_pkg::*;
#(
  parameter coeff_arr_t COEFFS = '{default: coeff_t'(0)}
) (
  input  wire          i_clk,
  input  wire          i_arst_n,
  input  wire          i_ena,
  input  wire sample_t i_data,
  output acc_t         o_ff_sum
);

  // ----------------------------------------
  // Signals
  // ----------------------------------------

  // Past inputs, x[n-1] first
  sample_t x_hist [HIST_DEPTH];

  // Current plus past inputs, x[n-k] at index k
  sample_t x_vec  [TAPS];

  // b[k] times x[n-k]
  acc_t    prod   [TAPS];

  acc_t    sum;

  // ----------------------------------------
  // Input history
  // ----------------------------------------

  iir_delay_line #(
    .T     (sample_t),
    .DEPTH (HIST_DEPTH)
  ) u_x_hist (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ena    (i_ena),
    .i_sample (i_data),
    .o_taps   (x_hist)
  );

  // ----------------------------------------
  // Numerator products
  // ----------------------------------------

  // Tap 0 is the sample on the port this cycle
  assign x_vec[0] = i_data;

  for (genvar k = 1; k < TAPS; k++)
  begin : g_x_vec
    assign x_vec[k] = x_hist[k-1];
  end

  // Both operands sign extended first so the product fits acc_t
  for (genvar k = 0; k < TAPS; k++)
  begin : g_prod
    assign prod[k] = acc_t'(x_vec[k]) * acc_t'(COEFFS[k]);
  end

  // ----------------------------------------
  // Sum
  // ----------------------------------------

  always_comb
  begin
    sum = '0;
    for (int k = 0; k < TAPS; k++)
    begin
      sum = sum + prod[k];
    end
  end

  // No register here, the output follows i_data
  assign o_ff_sum = sum;

endmodule : iir_feedforward

`default_nettype wire

//--- src/iir_feedback.sv
/*
 * IIR feedback section
 * Adds the denominator products of past outputs to the feed-forward
 * sum, wraps the total to output width and keeps it as history
 */

`timescale 1ns/1ns
`default_nettype none

module iir_feedback
  import iir_pkg::*;
#(
  parameter coeff_arr_t COEFFS = '{default: coeff_t'(0)}
) (
  input  wire       i_clk,
  input  wire       i_arst_n,
  input  wire       i_ena,
  input  wire acc_t i_ff_sum,
  output out_t      o_data
);

  // ----------------------------------------
  // Signals
  // ----------------------------------------

  // Past outputs, y[n-1] first
  out_t y_hist [HIST_DEPTH];

  // a[k] times y[n-k] for k from 1, stored at index k-1
  acc_t prod   [HIST_DEPTH];

  // Full-precision total before the wrap
  acc_t sum;

  // Wrapped output, also the next history entry
  out_t y_out;

  // ----------------------------------------
  // Output history
  // ----------------------------------------

  // Holds the wrapped value, the same one that leaves the block
  iir_delay_line #(
    .T     (out_t),
    .DEPTH (HIST_DEPTH)
  ) u_y_hist (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ena    (i_ena),
    .i_sample (y_out),
    .o_taps   (y_hist)
  );

  // ----------------------------------------
  // Denominator products
  // ----------------------------------------

  // a[0] has no place in the recursion
  for (genvar k = 1; k < TAPS; k++)
  begin : g_prod
    assign prod[k-1] = acc_t'(y_hist[k-1]) * acc_t'(COEFFS[k]);
  end

  // ----------------------------------------
  // Final sum
  // ----------------------------------------

  // Feed-forward part already summed upstream
  always_comb
  begin
    sum = i_ff_sum;
    for (int k = 0; k < HIST_DEPTH; k++)
    begin
      sum = sum + prod[k];
    end
  end

  // ----------------------------------------
  // Wrap to output width
  // ----------------------------------------

  // Two's complement wrap, upper accumulator bits are dropped
  assign y_out = out_t'(sum);

  assign o_data = y_out;

endmodule : iir_feedback

`default_nettype wire

//--- src/iir_filter_dfi.sv
/*
 * Direct-Form I IIR filter, top level
 * Feed-forward section feeding the feedback section, with the
 * output shown combinationally and histories shifted on i_ena
 */

`timescale 1ns/1ns
`default_nettype none

module iir_filter_dfi
  import iir_pkg::*;
#(
  // Numerator b[0..TAPS-1]
  parameter coeff_arr_t FF_COEFFS = '{coeff_t'(1), coeff_t'(2), coeff_t'(1)},
  // Denominator a[0..TAPS-1], a[0] not used
  parameter coeff_arr_t FB_COEFFS = '{coeff_t'(0), coeff_t'(1), coeff_t'(-1)}
) (
  input  wire          i_clk,
  input  wire          i_arst_n,
  input  wire          i_ena,
  input  wire sample_t i_data,
  output wire out_t    o_data
);

  // ----------------------------------------
  // Section link
  // ----------------------------------------

  // Numerator sum at full width, zero cycles after i_data
  wire acc_t ff_sum;

  // ----------------------------------------
  // Feed-forward section
  // ----------------------------------------

  iir_feedforward #(
    .COEFFS (FF_COEFFS)
  ) u_feedforward (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ena    (i_ena),
    .i_data   (i_data),
    .o_ff_sum (ff_sum)
  );

  // ----------------------------------------
  // Feedback section
  // ----------------------------------------

  // Closes the recursion and produces the wrapped output
  iir_feedback #(
    .COEFFS (FB_COEFFS)
  ) u_feedback (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ena    (i_ena),
    .i_ff_sum (ff_sum),
    .o_data   (o_data)
  );

endmodule : iir_filter_dfi

`default_nettype wire

//--- verification/iir_assertions.sv
/*
 * IIR filter port checks
 * Concurrent properties on the top-level ports, bound to the DUT
 */

`timescale 1ns/1ns
`default_nettype none

module iir_assertions
  import iir_pkg::*;
#(
  parameter coeff_arr_t FF_COEFFS = '{default: coeff_t'(0)}
) (
  input wire          i_clk,
  input wire          i_arst_n,
  input wire          i_ena,
  input wire sample_t i_data,
  input wire out_t    i_out
);

  // ----------------------------------------
  // Output always known out of reset
  // ----------------------------------------

  a_out_known : assert property (@(posedge i_clk) i_arst_n |-> !$isunknown(i_out))
    else $error("o_data has unknown bits while out of reset");

  // ----------------------------------------
  // Held state with a held input
  // ----------------------------------------

  // No shift on the previous edge, so same input means same output
  a_hold : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ($past(i_arst_n) && !$past(i_ena) && $stable(i_data)) |-> $stable(i_out))
    else $error("o_data changed while the enable was low and the input was held");

  // Cleared history leaves only the b[0] term
  a_reset_out : assert property (@(posedge i_clk)
    !i_arst_n |-> (i_out == out_t'(acc_t'(i_data) * acc_t'(FF_COEFFS[0]))))
    else $error("o_data differs from b[0] times the input during reset");

endmodule : iir_assertions

bind iir_filter_dfi iir_assertions #(
  .FF_COEFFS (FF_COEFFS)
) u_assertions (
  .i_clk    (i_clk),
  .i_arst_n (i_arst_n),
  .i_ena    (i_ena),
  .i_data   (i_data),
  .i_out    (o_data)
);

`default_nettype wire

//--- verification/tb_iir_filter.sv
/*
 * Testbench for the Direct-Form I IIR filter
 * Table-driven stimulus on the falling edge, checked just before
 * each rising edge against an integer reference model
 */

`timescale 1ns/1ns
`default_nettype none

module tb_iir_filter
  import iir_pkg::*;
();

  // ----------------------------------------
  // Run constants
  // ----------------------------------------

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 4;
  localparam int          NUM_TESTS    = 5;
  localparam int          NUM_RANDOM   = 60;
  localparam logic [31:0] RNG_SEED     = 32'hd0e1e718;

  // Table row with enable, reset request, sample and owning test
  typedef struct packed {
    logic    ena;
    logic    rst;
    sample_t sample;
    int      test_id;
  } entry_t;

  // ----------------------------------------
  // Signals and bookkeeping
  // ----------------------------------------

  logic     clk;
  logic     arst_n;
  logic     ena;
  sample_t  data_in;
  wire out_t data_out;

  entry_t   stim_q [$];

  // Model coefficients b[k] and a[k] of the default filter
  int b_coef [TAPS] = '{1, 2, 1};
  int a_coef [TAPS] = '{0, 1, -1};

  // Model history with the value k samples back at index k
  int x_hist [TAPS];
  int y_hist [TAPS];

  string test_name [NUM_TESTS] = '{"reset clears history", "impulse response",
                                   "enable low freezes state", "random samples",
                                   "reset in mid-run"};
  int test_checks [NUM_TESTS];
  int test_errors [NUM_TESTS];
  int pass_count;
  int fail_count;
  int cycle_count;
  int cycle_limit;

  // ----------------------------------------
  // DUT
  // ----------------------------------------

  iir_filter_dfi uut (
    .i_clk    (clk),
    .i_arst_n (arst_n),
    .i_ena    (ena),
    .i_data   (data_in),
    .o_data   (data_out)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // Guards against a stalled run
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Low OUT_W bits read back as a signed value
  function automatic int wrap_out(input longint value);
    logic [OUT_W-1:0] low;
    low = value[OUT_W-1:0];
    return int'(signed'(low));
  endfunction

  // Sum of b[k]x[n-k] and a[k]y[n-k] with a[0] left out
  function automatic int model_output(input int x);
    longint acc;
    acc = longint'(b_coef[0]) * longint'(x);
    for (int k = 1; k < TAPS; k++)
    begin
      acc = acc + longint'(b_coef[k]) * longint'(x_hist[k]);
      acc = acc + longint'(a_coef[k]) * longint'(y_hist[k]);
    end
    return wrap_out(acc);
  endfunction

  task automatic model_shift(input int x, input int y);
    for (int k = TAPS - 1; k > 1; k--)
    begin
      x_hist[k] = x_hist[k-1];
      y_hist[k] = y_hist[k-1];
    end
    x_hist[1] = x;
    y_hist[1] = y;
  endtask

  task automatic model_clear();
    for (int k = 0; k < TAPS; k++)
    begin
      x_hist[k] = 0;
      y_hist[k] = 0;
    end
  endtask

  // ----------------------------------------
  // Checks and reporting
  // ----------------------------------------

  task automatic check_out(input out_t actual, input out_t expected, input int test_id);
    test_checks[test_id]++;
    if (actual === expected)
      pass_count++;
    else
    begin
      fail_count++;
      test_errors[test_id]++;
      $display("error at %0t ns: o_data is %0d, expected %0d", $time, actual, expected);
    end
  endtask

  task automatic report_test(input int test_id);
    if (test_errors[test_id] == 0)
      $display("test %0d %s: %0d checks, ok", test_id, test_name[test_id],
               test_checks[test_id]);
    else
      $display("test %0d %s: %0d checks, %0d errors", test_id, test_name[test_id],
               test_checks[test_id], test_errors[test_id]);
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------

  task automatic add_entry(input logic en, input logic rst, input sample_t s, input int id);
    entry_t e;
    e.ena     = en;
    e.rst     = rst;
    e.sample  = s;
    e.test_id = id;
    stim_q.push_back(e);
  endtask

  task automatic add_repeat(input logic en, input sample_t s, input int n, input int id);
    for (int i = 0; i < n; i++)
    begin
      add_entry(en, 1'b0, s, id);
    end
  endtask

  task automatic add_random(input int n, input int id);
    for (int i = 0; i < n; i++)
    begin
      add_entry(1'b1, 1'b0, sample_t'($urandom), id);
    end
  endtask

  // Period-6 input at the pole frequency grows the output by about 1500 per period
  task automatic add_resonant(input int periods, input int id);
    sample_t pattern [6];
    pattern = '{sample_t'(127), sample_t'(127), sample_t'(0),
                sample_t'(-127), sample_t'(-127), sample_t'(0)};
    for (int i = 0; i < periods * 6; i++)
    begin
      add_entry(1'b1, 1'b0, pattern[i % 6], id);
    end
  endtask

  task automatic build_table();
    // Some history first so that the reset has something to clear
    add_entry(1'b1, 1'b0, sample_t'(50), 0);
    add_entry(1'b1, 1'b0, sample_t'(-30), 0);

    // Zero input through reset and after it
    add_entry(1'b0, 1'b1, sample_t'(0), 0);
    add_entry(1'b1, 1'b1, sample_t'(0), 0);
    add_repeat(1'b1, sample_t'(0), 5, 0);

    // Single unit sample after a fresh reset
    add_entry(1'b1, 1'b1, sample_t'(0), 1);
    add_entry(1'b1, 1'b0, sample_t'(1), 1);
    add_repeat(1'b1, sample_t'(0), 12, 1);

    // Enable low with the input held before resuming
    add_entry(1'b1, 1'b1, sample_t'(0), 2);
    add_entry(1'b1, 1'b0, sample_t'(5), 2);
    add_entry(1'b1, 1'b0, sample_t'(-7), 2);
    add_repeat(1'b0, sample_t'(-7), 4, 2);
    add_entry(1'b1, 1'b0, sample_t'(20), 2);
    add_repeat(1'b1, sample_t'(0), 2, 2);
    add_entry(1'b1, 1'b0, sample_t'(3), 2);
    add_entry(1'b1, 1'b0, sample_t'(0), 2);
    add_repeat(1'b0, sample_t'(0), 3, 2);
    add_entry(1'b1, 1'b0, sample_t'(-100), 2);
    add_entry(1'b1, 1'b0, sample_t'(0), 2);

    // Full-scale corners
    add_repeat(1'b1, sample_t'(127), 2, 3);
    add_repeat(1'b1, sample_t'(-128), 2, 3);

    // Resonant drive until the output wraps past OUT_W bits
    add_resonant(26, 3);

    add_random(NUM_RANDOM - 4, 3);

    // Reset lands between two random runs
    add_random(6, 4);
    add_entry(1'b1, 1'b1, sample_t'($urandom), 4);
    add_entry(1'b0, 1'b1, sample_t'($urandom), 4);
    add_random(8, 4);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial
  begin
    entry_t e;
    int     expected;
    int     current_test;

    void'($urandom(RNG_SEED));
    arst_n  = 1'b0;
    ena     = 1'b0;
    data_in = '0;
    model_clear();
    build_table();
    cycle_limit = stim_q.size() + RESET_CYCLES + 20;

    repeat (RESET_CYCLES) @(posedge clk);

    current_test = -1;
    foreach (stim_q[i])
    begin
      e = stim_q[i];
      if (e.test_id != current_test)
      begin
        if (current_test >= 0)
          report_test(current_test);
        current_test = e.test_id;
      end

      @(negedge clk);
      arst_n  = ~e.rst;
      ena     = e.ena;
      data_in = e.sample;
      if (e.rst)
        model_clear();
      expected = model_output(int'(e.sample));

      // Output has settled well before the rising edge
      #(CLK_PERIOD / 2 - 1);
      check_out(data_out, out_t'(expected), e.test_id);

      @(posedge clk);
      if (!e.rst && e.ena)
        model_shift(int'(e.sample), expected);
    end
    report_test(current_test);

    @(negedge clk);
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule : tb_iir_filter

`default_nettype wire

//--- flist.f
src/iir_pkg.sv
src/iir_delay_line.sv
src/iir_feedforward.sv
src/iir_feedback.sv
src/iir_filter_dfi.sv
verification/iir_assertions.sv
verification/tb_iir_filter.sv

//--- Makefile
# Verilator flow for the Direct-Form I IIR filter
# Every variable below can be overridden on the command line

VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_iir_filter
RTL_TOP    ?= iir_filter_dfi
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Result: PASSED
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

RTL_SRCS ?= src/iir_pkg.sv \
            src/iir_delay_line.sv \
            src/iir_feedforward.sv \
            src/iir_feedback.sv \
            src/iir_filter_dfi.sv

.PHONY: all lint build sim clean

all: sim

# Lint the synthesizable design on its own
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The run passes only if the log holds the pass line
sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
